// File: test/radar_stim.txt
# mode neg rate nsamp vid trig arp acp policy pulses word
# levels and word in hex, trig/arp/acp idle below relax; policy 1 withholds credits
# pulsed video, plain and negated
0 0 2 6 a5c 010 020 030 0 1 a5c
0 1 2 6 a5c 010 020 030 0 1 5a3
0 0 3 4 7ff 000 000 000 0 2 7ff
0 1 1 5 000 005 006 007 0 1 fff
0 0 2 3 123 010 020 030 0 0 123
# raw channels, negate has no effect here
1 0 2 10 3c4 011 022 033 0 0 3c4
1 1 2 6 3c4 011 022 033 0 0 3c4
2 0 3 8 abc 2b7 051 062 0 0 2b7
3 0 2 8 abc 011 3e7 062 0 0 3e7
4 0 4 5 abc 011 022 1a5 0 0 1a5
# long raw burst with credits held back
1 0 1 40 6d2 010 020 030 1 0 6d2

// File: sources.f
hw/radar_pkg.sv
hw/pulse_detect.sv
hw/burst_control.sv
hw/sample_capture.sv
hw/sample_out.sv
hw/radar_digitizer.sv
test/radar_properties.sv
test/tb_radar_digitizer.sv

// File: Makefile
# Verilator build and run of the radar digitizer testbench
TOP := tb_radar_digitizer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f sources.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "simulation stopped before the end"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: test/tb_radar_digitizer.sv
// testbench for the radar digitizer; replays the stim file records and checks words, counts and overrun
`default_nettype none

module tb_radar_digitizer
   import radar_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int    CLK_PERIOD   = 4;
   localparam int    RESET_CLOCKS = 2;
   localparam int    MAX_RECS     = 32;
   localparam string STIM_FILE    = "test/radar_stim.txt";
   localparam adc_t  EXCITE       = 12'd2000;   // same thresholds on all three detectors
   localparam adc_t  RELAX        = 12'd1000;

   typedef logic [63:0] value_t;

   logic   clk64 = 1'b0;
   logic   rx_dsp_reset;
   adc_t   vid_in, trig_in, arp_in, acp_in;
   logic   enable, vid_negate, clear_status;
   logic   credit_return = 1'b0;
   mode_t  mode;
   rate_t  decim_rate;
   count_t n_samples;
   word_t  out_data;
   logic   out_valid, overrun;
   count_t n_trigs, n_arps, n_acps, acp_count_at_arp;

   // one entry per stim record
   int r_mode[MAX_RECS], r_neg[MAX_RECS], r_rate[MAX_RECS], r_nsamp[MAX_RECS];
   int r_vid[MAX_RECS], r_trig[MAX_RECS], r_arp[MAX_RECS], r_acp[MAX_RECS];
   int r_policy[MAX_RECS], r_pulses[MAX_RECS], r_word[MAX_RECS];
   int     n_recs = 0;
   int     seed = 41;
   int     errors = 0;
   int     checks = 0;
   int     received = 0;                        // words seen in the current record
   int     owed = 0;                            // credits the sink still has to return
   int     exp_word = 0;
   bit     withhold = 1'b0;                     // sink keeps its credits
   longint budget = 0;                          // watchdog limit in clocks

   radar_digitizer dut_i (.clk64, .rx_dsp_reset, .vid_in, .trig_in, .arp_in, .acp_in,
      .enable, .mode, .vid_negate, .decim_rate, .n_samples,
      .trig_excite(EXCITE), .trig_relax(RELAX), .arp_excite(EXCITE), .arp_relax(RELAX),
      .acp_excite(EXCITE), .acp_relax(RELAX), .credit_return, .clear_status,
      .out_data, .out_valid, .overrun, .n_trigs, .n_arps, .n_acps, .acp_count_at_arp);

   always #(CLK_PERIOD / 2) clk64 = ~clk64;

   task automatic check(input string what, input value_t got, input value_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // all inputs change 1 ns after the rising edge
   task automatic wait_clocks(input int n);
      repeat (n)
      begin
         @(posedge clk64);
         #1;
      end
   endtask

   task automatic drive_channel(input int ch, input int value);
      case (ch)
         0:       trig_in = adc_t'(value);
         1:       arp_in  = adc_t'(value);
         default: acp_in  = adc_t'(value);
      endcase
   endtask

   // near miss, crossing, wiggle above relax, second peak, then back below relax
   // only the crossing counts
   task automatic pulse_channel(input int ch, input int idle);
      drive_channel(ch, 1900);
      wait_clocks(2);
      drive_channel(ch, 3000);
      wait_clocks(2);
      drive_channel(ch, 1500);
      wait_clocks(2);
      drive_channel(ch, 3000);
      wait_clocks(2);
      drive_channel(ch, idle);
      wait_clocks(4);
   endtask

   task automatic load_stim(output bit ok);
      int    fd;
      int    got;
      string line;
      fd = $fopen(STIM_FILE, "r");
      ok = (fd != 0);
      if (ok)
      begin
         while (!$feof(fd) && (n_recs < MAX_RECS))
         begin
            got = $fgets(line, fd);
            if ((got > 0) && (line.len() > 1) && (line.getc(0) != "#"))
            begin
               got = $sscanf(line, "%d %d %d %d %h %h %h %h %d %d %h", r_mode[n_recs],
                  r_neg[n_recs], r_rate[n_recs], r_nsamp[n_recs], r_vid[n_recs],
                  r_trig[n_recs], r_arp[n_recs], r_acp[n_recs], r_policy[n_recs],
                  r_pulses[n_recs], r_word[n_recs]);
               if (got == 11)
                  n_recs++;
            end
         end
         $fclose(fd);
         ok = (n_recs > 0);
      end
   endtask

   task automatic run_record(input int i);
      int target;
      bit hold;
      hold = (r_policy[i] != 0);
      enable = 1'b0;
      rx_dsp_reset = 1'b1;
      mode = mode_t'(r_mode[i]);
      vid_negate = r_neg[i][0];
      decim_rate = rate_t'(r_rate[i]);
      n_samples = count_t'(r_nsamp[i]);
      vid_in = adc_t'(r_vid[i]);
      trig_in = adc_t'(r_trig[i]);
      arp_in = adc_t'(r_arp[i]);
      acp_in = adc_t'(r_acp[i]);
      withhold = hold;
      exp_word = r_word[i];
      received = 0;
      wait_clocks(RESET_CLOCKS);
      rx_dsp_reset = 1'b0;
      enable = 1'b1;
      pulse_channel(0, r_trig[i]);              // lands inside the settling window
      wait_clocks(ENABLE_DELAY);
      if (r_mode[i] == 0)
      begin
         check("words from the early trigger", value_t'(received), '0);
         target = r_pulses[i] * r_nsamp[i];
         repeat (r_pulses[i])
         begin
            pulse_channel(0, r_trig[i]);
            wait_clocks(r_nsamp[i] * r_rate[i] + 10);   // burst over before the next one
         end
      end
      else if (hold)
      begin
         target = INIT_CREDITS + FIFO_DEPTH;
         wait (overrun === 1'b1);               // FIFO full and a word lost
         @(posedge clk64);
         #1;
         n_samples = '0;
         wait_clocks(r_nsamp[i] * r_rate[i] + 20);
         check("words with credits held", value_t'(received), value_t'(INIT_CREDITS));
         withhold = 1'b0;                       // pay back, the FIFO contents follow
      end
      else
         target = r_nsamp[i];
      wait (received >= target);
      @(posedge clk64);
      #1;
      n_samples = '0;                            // no new bursts, raw modes stop here
      wait_clocks(r_nsamp[i] * r_rate[i] + 30);  // running burst ends, FIFO drains
      if ((r_mode[i] == 0) || hold)
         check("words delivered", value_t'(received), value_t'(target));
      check("overrun", value_t'(overrun), value_t'(hold));
      if (hold)
      begin
         clear_status = 1'b1;
         wait_clocks(1);
         clear_status = 1'b0;
         wait_clocks(1);
         check("overrun after clear", value_t'(overrun), '0);
      end
      repeat (3) pulse_channel(0, r_trig[i]);
      repeat (3) pulse_channel(2, r_acp[i]);
      pulse_channel(1, r_arp[i]);               // heading mark after three ACPs
      repeat (2) pulse_channel(2, r_acp[i]);
      check("n_trigs", value_t'(n_trigs), value_t'(r_pulses[i] + 4));
      check("n_arps", value_t'(n_arps), value_t'(1));
      check("n_acps", value_t'(n_acps), value_t'(5));
      check("acp_count_at_arp", value_t'(acp_count_at_arp), value_t'(3));
      wait (owed == 0);
      @(posedge clk64);
      #1;
   endtask

   // sink: every word is checked and earns one credit back
   always @(negedge clk64)
   begin
      if (out_valid === 1'b1)
      begin
         received = received + 1;
         owed = owed + 1;
         check("output word", value_t'(out_data), value_t'(exp_word));
      end
   end

   // credit return after a random gap of 0 to 3 clocks
   always
   begin
      int gap;
      @(posedge clk64);
      #1;
      credit_return = 1'b0;
      if (!withhold && (owed > 0))
      begin
         gap = $unsigned($random(seed)) % 4;
         wait_clocks(gap);
         credit_return = 1'b1;
         owed = owed - 1;
      end
   end

   initial
   begin
      wait (budget > 0);
      #(budget * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d clocks", budget);
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      bit ok;
      rx_dsp_reset = 1'b1;
      enable = 1'b0;
      clear_status = 1'b0;
      mode = mode_video;
      vid_negate = 1'b0;
      decim_rate = rate_t'(1);
      n_samples = '0;
      vid_in = '0;
      trig_in = '0;
      arp_in = '0;
      acp_in = '0;
      load_stim(ok);
      if (!ok)
      begin
         $display("the stimulus file %s is missing or holds no records", STIM_FILE);
         $display("Done: errors found");
         $finish;
      end
      else
      begin
         // pulse and count phases take a few hundred clocks, bursts scale with the record
         for (int i = 0; i < n_recs; i++)
            budget += longint'((r_pulses[i] + 3) * r_nsamp[i] * r_rate[i] + 400);
         for (int i = 0; i < n_recs; i++)
            run_record(i);
         $display("records %0d, checks %0d, errors %0d", n_recs, checks, errors);
         if (errors == 0)
            $display("Done: no errors");
         else
            $display("Done: errors found");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: test/radar_properties.sv
// concurrent checks on the output stage handshake and overrun flag; bound into every sample_out
`default_nettype none

module sample_out_properties
   import radar_pkg::*;
(
   input wire                clk64,
   input wire                rx_dsp_reset,
   input wire                out_valid,
   input wire                overrun,
   input wire                clear_status,
   input wire [CREDIT_W-1:0] credits
);
   timeunit 1ns;
   timeprecision 100ps;

   // every delivered word was backed by a credit on the clock before
   credit_guard: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      out_valid |-> $past(credits != '0))
      else $error("out_valid with no credits left");

   reset_quiet: assert property (@(posedge clk64) $past(rx_dsp_reset) |-> !out_valid)
      else $error("out_valid high during reset");

   // sticky until cleared
   overrun_sticky: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (overrun && !clear_status) |=> overrun)
      else $error("overrun dropped without clear_status");

endmodule

bind sample_out sample_out_properties props_i (.clk64, .rx_dsp_reset, .out_valid, .overrun,
   .clear_status, .credits);

`default_nettype wire

// File: hw/radar_digitizer.sv
// top level of the marine radar pulse digitizer; wires detectors, burst control, capture and output stage
`default_nettype none

module radar_digitizer
   import radar_pkg::*;
(
   input  wire         clk64,
   input  wire         rx_dsp_reset,
   // baseband inputs
   input  wire adc_t   vid_in,
   input  wire adc_t   trig_in,
   input  wire adc_t   arp_in,          // heading mark
   input  wire adc_t   acp_in,          // azimuth count pulses
   // configuration, static during a burst
   input  wire         enable,
   input  wire mode_t  mode,
   input  wire         vid_negate,
   input  wire rate_t  decim_rate,
   input  wire count_t n_samples,
   input  wire adc_t   trig_excite,
   input  wire adc_t   trig_relax,
   input  wire adc_t   arp_excite,
   input  wire adc_t   arp_relax,
   input  wire adc_t   acp_excite,
   input  wire adc_t   acp_relax,
   // sink side
   input  wire         credit_return,
   input  wire         clear_status,
   output word_t       out_data,
   output logic        out_valid,
   output logic        overrun,
   // status
   output count_t      n_trigs,
   output count_t      n_arps,
   output count_t      n_acps,
   output count_t      acp_count_at_arp // ACP count latched on each heading mark
);

   logic   trig_strobe;
   logic   arp_strobe;
   logic   sample_tick;
   word_t  cap_data;
   logic   cap_valid;

   // decode, one detector per pulse input
   pulse_detect detect_trig (.clk64, .rx_dsp_reset, .enable, .level(trig_in),
      .excite(trig_excite), .relax(trig_relax), .strobe(trig_strobe), .count(n_trigs));
   pulse_detect detect_arp (.clk64, .rx_dsp_reset, .enable, .level(arp_in),
      .excite(arp_excite), .relax(arp_relax), .strobe(arp_strobe), .count(n_arps));
   // only the ACP count is used here
   pulse_detect detect_acp (.clk64, .rx_dsp_reset, .enable, .level(acp_in),
      .excite(acp_excite), .relax(acp_relax), .strobe(), .count(n_acps));

   // execute, when to sample
   burst_control burst_ctl (.clk64, .rx_dsp_reset, .enable, .mode, .trig_strobe,
      .decim_rate, .n_samples, .active(), .sample_tick);

   // and what to sample
   sample_capture capture (.clk64, .rx_dsp_reset, .sample_tick, .mode, .vid_negate,
      .vid_in, .trig_in, .arp_in, .acp_in, .cap_data, .cap_valid);

   // result, buffering and credits
   sample_out out_stage (.clk64, .rx_dsp_reset, .cap_data, .cap_valid, .credit_return,
      .clear_status, .out_data, .out_valid, .overrun);

   // azimuth at heading, the ACP strobe on the same clock is not yet in n_acps
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         acp_count_at_arp <= '0;
      else if (arp_strobe)
         acp_count_at_arp <= n_acps;
   end

endmodule

`default_nettype wire

// File: hw/sample_out.sv
// output stage: small word FIFO drained under credit-based flow control, with sticky overrun on drops
`default_nettype none

module sample_out
   import radar_pkg::*;
(
   input  wire        clk64,
   input  wire        rx_dsp_reset,
   input  wire word_t cap_data,
   input  wire        cap_valid,
   input  wire        credit_return,    // sink consumed one word
   input  wire        clear_status,     // clears overrun
   output word_t      out_data,
   output logic       out_valid,        // one clock per delivered word
   output logic       overrun           // sticky, a word was dropped
);

   word_t                mem [FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [PTR_W:0]       fill;          // words held, 0 to FIFO_DEPTH
   logic [CREDIT_W-1:0]  credits;       // words the sink can still accept
   logic                 full;
   logic                 push;
   logic                 pop;

   assign full = fill[PTR_W];           // depth is a power of two so msb set means full
   assign push = cap_valid && !full;    // a word arriving while full is lost
   assign pop  = (fill != '0) && (credits != '0);

   // storage and output data
   always_ff @(posedge clk64)
   begin
      if (push)
         mem[wr_ptr] <= cap_data;
      if (pop)
         out_data <= mem[rd_ptr];
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         credits   <= CREDIT_W'(INIT_CREDITS);
         out_valid <= 1'b0;
         overrun   <= 1'b0;
      end
      else
      begin
         out_valid <= pop;
         if (push)
            wr_ptr <= wr_ptr + 1'b1;    // pointers wrap at the depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;      // both or neither
         endcase
         // one credit out per word, one back per return pulse
         case ({pop, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         if (clear_status)
            overrun <= 1'b0;
         if (cap_valid && full)
            overrun <= 1'b1;            // a drop on the clear clock still sets it
      end
   end

endmodule

`default_nettype wire

// File: hw/sample_capture.sv
// picks the channel for the capture mode, optionally negates video and registers one word per decimation tick
`default_nettype none

module sample_capture
   import radar_pkg::*;
(
   input  wire        clk64,
   input  wire        rx_dsp_reset,
   input  wire        sample_tick,      // from burst_control
   input  wire mode_t mode,
   input  wire        vid_negate,       // only honoured in pulsed video mode
   input  wire adc_t  vid_in,
   input  wire adc_t  trig_in,
   input  wire adc_t  arp_in,
   input  wire adc_t  acp_in,
   output word_t      cap_data,         // captured word, valid with cap_valid
   output logic       cap_valid         // one clock after each tick
);

   adc_t sel;                           // channel chosen for this mode

   // channel mux
   always_comb
   begin
      case (mode)
         mode_video:
         begin
            // some receivers give inverted video
            if (vid_negate)
               sel = ADC_FULL_SCALE - vid_in;
            else
               sel = vid_in;
         end
         mode_raw_video:
            sel = vid_in;
         mode_raw_trig:
            sel = trig_in;
         mode_raw_arp:
            sel = arp_in;
         mode_raw_acp:
            sel = acp_in;
         default:
            sel = '0;                   // unused mode codes give zeros
      endcase
   end

   // word register, loads only on a tick
   always_ff @(posedge clk64)
   begin
      if (sample_tick)
         cap_data <= {{(WORD_W - ADC_W){1'b0}}, sel};   // zero-extend to 16 bits
   end

   // valid flag trails the tick by one clock
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         cap_valid <= 1'b0;
      else
         cap_valid <= sample_tick;
   end

endmodule

`default_nettype wire

// File: hw/burst_control.sv
// burst sequencer: enable settling delay, pulsed or free-running burst start, sample countdown and decimation tick
`default_nettype none

module burst_control
   import radar_pkg::*;
(
   input  wire         clk64,
   input  wire         rx_dsp_reset,
   input  wire         enable,
   input  wire mode_t  mode,
   input  wire         trig_strobe,       // from the trigger detector
   input  wire rate_t  decim_rate,        // clocks between samples
   input  wire count_t n_samples,         // samples per burst
   output logic        active,            // burst in progress
   output logic        sample_tick        // take one sample this clock
);

   burst_state_t state;
   count_t       settle_cnt;              // clocks since enable rose
   count_t       remaining;               // samples still to take in this burst
   rate_t        decim_cnt;               // clocks until the next tick
   logic         start;                   // first clock of a burst
   logic         pulsed;                  // burst per trigger rather than free-running

   assign pulsed = (mode == mode_video);
   assign active = (state == st_burst);

   // first tick on the start clock, then each time the down-counter runs out
   assign sample_tick = start | (active && (decim_cnt == '0));

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         state      <= st_settle;
         settle_cnt <= '0;
         remaining  <= '0;
         decim_cnt  <= '0;
         start      <= 1'b0;
      end
      else if (!enable)
      begin
         state      <= st_settle;         // back to settling at once, any burst is abandoned
         settle_cnt <= '0;
         start      <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            st_settle:
            begin
               if (settle_cnt == count_t'(ENABLE_DELAY - 1))
                  state <= st_idle;
               else
                  settle_cnt <= settle_cnt + count_t'(1);
            end
            st_idle:
            begin
               // pulsed mode waits for a trigger, raw modes go straight away
               if ((!pulsed || trig_strobe) && (n_samples != '0))
               begin
                  state     <= st_burst;
                  start     <= 1'b1;
                  remaining <= n_samples;
               end
            end
            st_burst:
            begin
               // trig_strobe is ignored in here
               if (sample_tick)
               begin
                  // rate of 0 or 1 means a tick every clock
                  decim_cnt <= (decim_rate > rate_t'(1)) ? decim_rate - rate_t'(1) : '0;
                  if (remaining <= count_t'(1))
                     state <= st_idle;   // last sample taken
                  else
                     remaining <= remaining - count_t'(1);
               end
               else if (decim_cnt != '0)
               begin
                  decim_cnt <= decim_cnt - rate_t'(1);
               end
            end
            default:
            begin
               state <= st_settle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/pulse_detect.sv
// threshold-with-hysteresis edge detector giving a one-clock strobe and a running count per crossing
`default_nettype none

module pulse_detect
   import radar_pkg::*;
(
   input  wire        clk64,
   input  wire        rx_dsp_reset,
   input  wire        enable,            // strobe and count only while high
   input  wire adc_t  level,             // analog level from the ADC
   input  wire adc_t  excite,            // rising threshold, fires the detector
   input  wire adc_t  relax,             // falling threshold, re-arms the detector
   output logic       strobe,            // one clock per arming crossing
   output count_t     count              // crossings seen since reset
);

   // armed waits for excite, fired waits for relax
   typedef enum logic
   {
      st_armed,
      st_fired
   } det_state_t;

   det_state_t state;
   adc_t       level_q;                  // registered input level

   // first stage, just the input register
   always_ff @(posedge clk64)
   begin
      level_q <= level;
   end

   // second stage, compare and hysteresis
   // the strobe lands 2 clocks after the level first crosses excite
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         state  <= st_armed;
         strobe <= 1'b0;
         count  <= '0;
      end
      else
      begin
         strobe <= 1'b0;                 // default, pulse lasts one clock
         case (state)
            st_armed:
            begin
               if (level_q >= excite)
               begin
                  state <= st_fired;     // fire even if disabled so a held level is not counted later
                  if (enable)
                  begin
                     strobe <= 1'b1;
                     count  <= count + count_t'(1);
                  end
               end
            end
            st_fired:
            begin
               // wiggles between relax and excite keep us here
               if (level_q < relax)
                  state <= st_armed;
            end
            default:
            begin
               state <= st_armed;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/radar_pkg.sv
// shared widths, types, capture modes and constants for the radar digitizer; import with radar_pkg::*
`default_nettype none

package radar_pkg;

   // widths that carry a meaning
   localparam int ADC_W   = 12;                // one baseband ADC sample
   localparam int WORD_W  = 16;                // one output word
   localparam int COUNT_W = 32;                // event counts and burst lengths
   localparam int RATE_W  = 16;                // decimation rate

   typedef logic [ADC_W-1:0]   adc_t;          // raw 12-bit sample
   typedef logic [WORD_W-1:0]  word_t;         // sample zero-extended to 16 bits
   typedef logic [COUNT_W-1:0] count_t;        // counts of triggers, ARPs, ACPs, samples
   typedef logic [RATE_W-1:0]  rate_t;         // clocks per sample

   // capture mode, 0 is pulsed, the rest free-run
   typedef enum logic [2:0]
   {
      mode_video     = 3'd0,                   // video, one burst per trigger, optional negate
      mode_raw_video = 3'd1,                   // raw video, back-to-back bursts
      mode_raw_trig  = 3'd2,                   // raw trigger channel
      mode_raw_arp   = 3'd3,                   // raw heading mark channel
      mode_raw_acp   = 3'd4                    // raw azimuth count channel
   } mode_t;

   // burst sequencer
   typedef enum logic [1:0]
   {
      st_settle,                               // waiting out the enable delay
      st_idle,                                 // ready, waiting for a start condition
      st_burst                                 // taking samples
   } burst_state_t;

   localparam adc_t ADC_FULL_SCALE = 12'd4095; // negated video is full scale minus input

   localparam int ENABLE_DELAY = 16;           // clocks from enable high until capture may start

   // output stage
   localparam int FIFO_DEPTH   = 8;            // words buffered, power of two
   localparam int PTR_W        = $clog2(FIFO_DEPTH);
   localparam int INIT_CREDITS = 4;            // credits granted by the sink after reset
   localparam int CREDIT_W     = 4;            // credit counter width

endpackage

`default_nettype wire
